// File: files.f
+incdir+test
logic/nbody_bus_pkg.sv
logic/nbody_calc_pkg.sv
logic/body_ram.sv
logic/nbody_regs.sv
logic/nbody_sequencer.sv
logic/pair_accel.sv
logic/nbody_top.sv
test/nbody_tb.sv

// File: logic/body_ram.sv
`default_nettype none

module body_ram #(
    parameter int BODIES = 512,
    localparam int BODY_ADDR_WIDTH = $clog2(BODIES)
) (
    input  wire                                   clk,
    input  wire [BODY_ADDR_WIDTH-1:0]             addr_a_i,
    input  wire [BODY_ADDR_WIDTH-1:0]             addr_b_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  data_a_i,
    input  wire                                   we_a_i,
    output logic [nbody_calc_pkg::DATA_WIDTH-1:0] q_a_o,
    output logic [nbody_calc_pkg::DATA_WIDTH-1:0] q_b_o
);
    import nbody_calc_pkg::*;

    logic [DATA_WIDTH-1:0] mem [0:BODIES-1];

    // Port a reads the old word when it writes
    always_ff @(posedge clk) begin
        if (we_a_i) begin
            mem[addr_a_i] <= data_a_i;
        end
        q_a_o <= mem[addr_a_i];
        q_b_o <= mem[addr_b_i];
    end

endmodule

`default_nettype wire

// File: logic/nbody_bus_pkg.sv
`default_nettype none

package nbody_bus_pkg;

    parameter int EXT_DATA_WIDTH = 32;
    parameter int ADDR_WIDTH     = 16;
    parameter int OPCODE_WIDTH   = 7;

    // Upper address field, body index sits below it
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_GO       = 7'h40,
        OP_READ     = 7'h41,
        OP_N_BODIES = 7'h42,
        OP_GAP      = 7'h43,
        OP_X_LO     = 7'h44,
        OP_X_HI     = 7'h45,
        OP_Y_LO     = 7'h46,
        OP_Y_HI     = 7'h47,
        OP_M_LO     = 7'h48,
        OP_M_HI     = 7'h49,
        OP_VX_LO    = 7'h4a,
        OP_VX_HI    = 7'h4b,
        OP_VY_LO    = 7'h4c,
        OP_VY_HI    = 7'h4d,
        OP_DONE     = 7'h50,
        OP_RD_X_LO  = 7'h51,
        OP_RD_X_HI  = 7'h52,
        OP_RD_Y_LO  = 7'h53,
        OP_RD_Y_HI  = 7'h54
    } bus_op_e;

endpackage

`default_nettype wire

// File: logic/nbody_calc_pkg.sv
`default_nettype none

package nbody_calc_pkg;

    // Signed fixed-point body data
    parameter int DATA_WIDTH = 64;

    // Each pair term is scaled down by this before summing
    parameter int FORCE_SHIFT = 8;

    // Pair issue to velocity write
    parameter int PAIR_LATENCY = 5;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ACCEL,
        PH_DRAIN,
        PH_POS
    } phase_e;

endpackage

`default_nettype wire

// File: logic/nbody_regs.sv
`default_nettype none

module nbody_regs #(
    parameter int BODIES = 512,
    localparam int BODY_ADDR_WIDTH = $clog2(BODIES)
) (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire                                       chipselect_i,
    input  wire                                       write_i,
    input  wire                                       read_i,
    input  wire [nbody_bus_pkg::ADDR_WIDTH-1:0]       addr_i,
    input  wire [nbody_bus_pkg::EXT_DATA_WIDTH-1:0]   writedata_i,
    input  wire                                       run_done_i,
    input  wire nbody_calc_pkg::phase_e               phase_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]      x_rd_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]      y_rd_i,
    output logic [nbody_bus_pkg::EXT_DATA_WIDTH-1:0]  readdata_o,
    output logic                                      go_o,
    output logic [BODY_ADDR_WIDTH:0]                  n_bodies_o,
    output logic [BODY_ADDR_WIDTH-1:0]                gap_o,
    output logic [BODY_ADDR_WIDTH-1:0]                bus_body_addr_o,
    output logic [nbody_calc_pkg::DATA_WIDTH-1:0]     wr_word_o,
    output logic                                      wr_x_o,
    output logic                                      wr_y_o,
    output logic                                      wr_m_o,
    output logic                                      wr_vx_o,
    output logic                                      wr_vy_o
);
    import nbody_bus_pkg::*;
    import nbody_calc_pkg::*;

    bus_op_e                   op;
    logic                      bus_wr;
    logic                      idle_wr;
    logic                      go_q;
    logic                      read_q;
    logic                      done_q;
    logic [EXT_DATA_WIDTH-1:0] stage_q;
    logic                      rd_valid_q;
    bus_op_e                   rd_op_q;

    assign op              = bus_op_e'(addr_i[ADDR_WIDTH-1 -: OPCODE_WIDTH]);
    assign bus_wr          = chipselect_i && write_i;
    assign bus_body_addr_o = addr_i[BODY_ADDR_WIDTH-1:0];

    // Engine may only start once the previous result has been collected
    assign go_o = go_q && !read_q && !done_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            go_q       <= 1'b0;
            read_q     <= 1'b0;
            done_q     <= 1'b0;
            n_bodies_o <= '0;
            gap_o      <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= chipselect_i && read_i;
            if (bus_wr) begin
                case (op)
                    OP_GO:       go_q <= writedata_i[0];
                    OP_READ:     read_q <= writedata_i[0];
                    OP_N_BODIES: n_bodies_o <= writedata_i[BODY_ADDR_WIDTH:0];
                    OP_GAP:      gap_o <= writedata_i[BODY_ADDR_WIDTH-1:0];
                    default:     ;
                endcase
            end
            // A finishing run wins over a clear in the same cycle
            if (run_done_i) begin
                done_q <= 1'b1;
            end else if (bus_wr && op == OP_READ && writedata_i[0]) begin
                done_q <= 1'b0;
            end
        end
    end

    // Low half waits here until its high half arrives
    always_ff @(posedge clk) begin
        if (bus_wr && op inside {OP_X_LO, OP_Y_LO, OP_M_LO, OP_VX_LO, OP_VY_LO}) begin
            stage_q <= writedata_i;
        end
        rd_op_q <= op;
    end

    assign wr_word_o = {writedata_i, stage_q};
    assign idle_wr   = bus_wr && phase_i == PH_IDLE;
    assign wr_x_o    = idle_wr && op == OP_X_HI;
    assign wr_y_o    = idle_wr && op == OP_Y_HI;
    assign wr_m_o    = idle_wr && op == OP_M_HI;
    assign wr_vx_o   = idle_wr && op == OP_VX_HI;
    assign wr_vy_o   = idle_wr && op == OP_VY_HI;

    // Memory port a answers one cycle after the request
    always_comb begin
        readdata_o = '0;
        if (rd_valid_q) begin
            case (rd_op_q)
                OP_DONE:    readdata_o = {{(EXT_DATA_WIDTH-1){1'b0}}, done_q};
                OP_RD_X_LO: readdata_o = x_rd_i[EXT_DATA_WIDTH-1:0];
                OP_RD_X_HI: readdata_o = x_rd_i[DATA_WIDTH-1:EXT_DATA_WIDTH];
                OP_RD_Y_LO: readdata_o = y_rd_i[EXT_DATA_WIDTH-1:0];
                OP_RD_Y_HI: readdata_o = y_rd_i[DATA_WIDTH-1:EXT_DATA_WIDTH];
                default:    readdata_o = '1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/nbody_sequencer.sv
`default_nettype none

module nbody_sequencer #(
    parameter int BODIES = 512,
    localparam int BODY_ADDR_WIDTH = $clog2(BODIES)
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   go_i,
    input  wire [BODY_ADDR_WIDTH:0]               n_bodies_i,
    input  wire [BODY_ADDR_WIDTH-1:0]             gap_i,
    input  wire [BODY_ADDR_WIDTH-1:0]             bus_body_addr_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  wr_word_i,
    input  wire                                   wr_x_i,
    input  wire                                   wr_y_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  x_b_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  y_b_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  vx_b_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  vy_b_i,
    output nbody_calc_pkg::phase_e                phase_o,
    output logic                                  run_done_o,
    output logic [BODY_ADDR_WIDTH-1:0]            addr_a_o,
    output logic [BODY_ADDR_WIDTH-1:0]            addr_b_o,
    output logic [nbody_calc_pkg::DATA_WIDTH-1:0] x_data_o,
    output logic [nbody_calc_pkg::DATA_WIDTH-1:0] y_data_o,
    output logic                                  x_we_o,
    output logic                                  y_we_o,
    output logic [BODY_ADDR_WIDTH-1:0]            v_rd_addr_o,
    output logic                                  pair_valid_o,
    output logic                                  pair_last_o,
    output logic [BODY_ADDR_WIDTH-1:0]            body_i_o
);
    import nbody_calc_pkg::*;

    localparam int DRAIN_WIDTH = $clog2(PAIR_LATENCY);

    phase_e                     phase_q;
    logic [BODY_ADDR_WIDTH-1:0] i_q;
    logic [BODY_ADDR_WIDTH-1:0] j_q;
    logic [DRAIN_WIDTH-1:0]     drain_q;
    logic [BODY_ADDR_WIDTH:0]   k_q;
    logic [BODY_ADDR_WIDTH:0]   k_wr;
    logic [BODY_ADDR_WIDTH-1:0] step_q;
    logic [BODY_ADDR_WIDTH-1:0] last_idx;
    logic [BODY_ADDR_WIDTH-1:0] last_step;
    logic                       last_pair;
    logic                       drain_end;
    logic                       pos_end;
    logic                       pos_wr;

    assign last_idx  = n_bodies_i[BODY_ADDR_WIDTH-1:0] - 1'b1;
    // GAP of zero still runs a single step
    assign last_step = (gap_i == '0) ? '0 : gap_i - 1'b1;
    assign last_pair = i_q == last_idx && j_q == last_idx;
    assign drain_end = drain_q == DRAIN_WIDTH'(PAIR_LATENCY - 1);

    // Position phase reads k at t and writes it back at t + 1
    assign pos_end = k_q == n_bodies_i + 1'b1;
    assign pos_wr  = phase_q == PH_POS && k_q != '0 && k_q <= n_bodies_i;
    assign k_wr    = k_q - 1'b1;

    assign run_done_o   = phase_q == PH_POS && pos_end && step_q == last_step;
    assign pair_valid_o = phase_q == PH_ACCEL;
    assign pair_last_o  = j_q == last_idx;
    assign body_i_o     = i_q;
    assign phase_o      = phase_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q <= PH_IDLE;
            i_q     <= '0;
            j_q     <= '0;
            drain_q <= '0;
            k_q     <= '0;
            step_q  <= '0;
        end else if (!go_i) begin
            phase_q <= PH_IDLE;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    phase_q <= PH_ACCEL;
                    i_q     <= '0;
                    j_q     <= '0;
                    step_q  <= '0;
                end
                PH_ACCEL: begin
                    if (last_pair) begin
                        phase_q <= PH_DRAIN;
                        drain_q <= '0;
                    end else if (j_q == last_idx) begin
                        j_q <= '0;
                        i_q <= i_q + 1'b1;
                    end else begin
                        j_q <= j_q + 1'b1;
                    end
                end
                PH_DRAIN: begin
                    drain_q <= drain_q + 1'b1;
                    if (drain_end) begin
                        phase_q <= PH_POS;
                        k_q     <= '0;
                    end
                end
                PH_POS: begin
                    k_q <= k_q + 1'b1;
                    if (run_done_o) begin
                        phase_q <= PH_IDLE;
                    end else if (pos_end) begin
                        phase_q <= PH_ACCEL;
                        step_q  <= step_q + 1'b1;
                        i_q     <= '0;
                        j_q     <= '0;
                    end
                end
                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    // Port a carries body i, port b body j; the bus owns port a at rest
    always_comb begin
        addr_a_o    = i_q;
        addr_b_o    = j_q;
        v_rd_addr_o = i_q;
        x_data_o    = x_b_i + vx_b_i;
        y_data_o    = y_b_i + vy_b_i;
        x_we_o      = 1'b0;
        y_we_o      = 1'b0;
        case (phase_q)
            PH_IDLE: begin
                addr_a_o    = bus_body_addr_i;
                addr_b_o    = bus_body_addr_i;
                v_rd_addr_o = bus_body_addr_i;
                x_data_o    = wr_word_i;
                y_data_o    = wr_word_i;
                x_we_o      = wr_x_i;
                y_we_o      = wr_y_i;
            end
            PH_POS: begin
                addr_a_o    = k_wr[BODY_ADDR_WIDTH-1:0];
                addr_b_o    = k_q[BODY_ADDR_WIDTH-1:0];
                v_rd_addr_o = k_q[BODY_ADDR_WIDTH-1:0];
                x_we_o      = pos_wr;
                y_we_o      = pos_wr;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/nbody_top.sv
`default_nettype none

module nbody_top #(
    parameter int BODIES = 512
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      chipselect_i,
    input  wire                                      write_i,
    input  wire                                      read_i,
    input  wire [nbody_bus_pkg::ADDR_WIDTH-1:0]      addr_i,
    input  wire [nbody_bus_pkg::EXT_DATA_WIDTH-1:0]  writedata_i,
    output logic [nbody_bus_pkg::EXT_DATA_WIDTH-1:0] readdata_o
);
    import nbody_calc_pkg::*;

    localparam int BODY_ADDR_WIDTH = $clog2(BODIES);

    phase_e                     phase;
    logic                       run_done;
    logic                       go;
    logic [BODY_ADDR_WIDTH:0]   n_bodies;
    logic [BODY_ADDR_WIDTH-1:0] gap;
    logic [BODY_ADDR_WIDTH-1:0] bus_body_addr;
    logic [DATA_WIDTH-1:0]      wr_word;
    logic                       wr_x, wr_y, wr_m, wr_vx, wr_vy;
    logic [BODY_ADDR_WIDTH-1:0] addr_a, addr_b, v_rd_addr;
    logic [DATA_WIDTH-1:0]      x_data, y_data;
    logic                       x_we, y_we;
    logic                       pair_valid, pair_last;
    logic [BODY_ADDR_WIDTH-1:0] body_i;
    logic                       vel_we;
    logic [BODY_ADDR_WIDTH-1:0] vel_addr;
    logic [DATA_WIDTH-1:0]      vx_new, vy_new;
    logic [BODY_ADDR_WIDTH-1:0] v_addr_a;
    logic [DATA_WIDTH-1:0]      vx_data, vy_data;
    logic                       vx_we, vy_we;
    logic [DATA_WIDTH-1:0]      x_qa, x_qb, y_qa, y_qb, m_qb, vx_qb, vy_qb;

    // Velocity port a belongs to the bus at rest and to the accumulator in a run
    assign v_addr_a = (phase == PH_IDLE) ? bus_body_addr : vel_addr;
    assign vx_data  = (phase == PH_IDLE) ? wr_word : vx_new;
    assign vy_data  = (phase == PH_IDLE) ? wr_word : vy_new;
    assign vx_we    = wr_vx || vel_we;
    assign vy_we    = wr_vy || vel_we;

    nbody_regs #(.BODIES(BODIES)) regs0 (
        .clk(clk), .rst(rst), .chipselect_i(chipselect_i), .write_i(write_i),
        .read_i(read_i), .addr_i(addr_i), .writedata_i(writedata_i),
        .run_done_i(run_done), .phase_i(phase), .x_rd_i(x_qa), .y_rd_i(y_qa),
        .readdata_o(readdata_o), .go_o(go), .n_bodies_o(n_bodies), .gap_o(gap),
        .bus_body_addr_o(bus_body_addr), .wr_word_o(wr_word), .wr_x_o(wr_x),
        .wr_y_o(wr_y), .wr_m_o(wr_m), .wr_vx_o(wr_vx), .wr_vy_o(wr_vy)
    );

    nbody_sequencer #(.BODIES(BODIES)) seq0 (
        .clk(clk), .rst(rst), .go_i(go), .n_bodies_i(n_bodies), .gap_i(gap),
        .bus_body_addr_i(bus_body_addr), .wr_word_i(wr_word), .wr_x_i(wr_x),
        .wr_y_i(wr_y), .x_b_i(x_qb), .y_b_i(y_qb), .vx_b_i(vx_qb), .vy_b_i(vy_qb),
        .phase_o(phase), .run_done_o(run_done), .addr_a_o(addr_a), .addr_b_o(addr_b),
        .x_data_o(x_data), .y_data_o(y_data), .x_we_o(x_we), .y_we_o(y_we),
        .v_rd_addr_o(v_rd_addr), .pair_valid_o(pair_valid), .pair_last_o(pair_last),
        .body_i_o(body_i)
    );

    pair_accel #(.BODIES(BODIES)) accel0 (
        .clk(clk), .rst(rst), .pair_valid_i(pair_valid), .pair_last_i(pair_last),
        .body_i_i(body_i), .xi_i(x_qa), .yi_i(y_qa), .xj_i(x_qb), .yj_i(y_qb),
        .mj_i(m_qb), .vx_i(vx_qb), .vy_i(vy_qb), .vel_we_o(vel_we),
        .vel_addr_o(vel_addr), .vx_new_o(vx_new), .vy_new_o(vy_new)
    );

    body_ram #(.BODIES(BODIES)) x_ram (
        .clk(clk), .addr_a_i(addr_a), .addr_b_i(addr_b), .data_a_i(x_data),
        .we_a_i(x_we), .q_a_o(x_qa), .q_b_o(x_qb)
    );

    body_ram #(.BODIES(BODIES)) y_ram (
        .clk(clk), .addr_a_i(addr_a), .addr_b_i(addr_b), .data_a_i(y_data),
        .we_a_i(y_we), .q_a_o(y_qa), .q_b_o(y_qb)
    );

    // Mass is only loaded by the bus and read as body j
    body_ram #(.BODIES(BODIES)) m_ram (
        .clk(clk), .addr_a_i(addr_a), .addr_b_i(addr_b), .data_a_i(wr_word),
        .we_a_i(wr_m), .q_a_o(), .q_b_o(m_qb)
    );

    body_ram #(.BODIES(BODIES)) vx_ram (
        .clk(clk), .addr_a_i(v_addr_a), .addr_b_i(v_rd_addr), .data_a_i(vx_data),
        .we_a_i(vx_we), .q_a_o(), .q_b_o(vx_qb)
    );

    body_ram #(.BODIES(BODIES)) vy_ram (
        .clk(clk), .addr_a_i(v_addr_a), .addr_b_i(v_rd_addr), .data_a_i(vy_data),
        .we_a_i(vy_we), .q_a_o(), .q_b_o(vy_qb)
    );

endmodule

`default_nettype wire

// File: logic/pair_accel.sv
`default_nettype none

module pair_accel #(
    parameter int BODIES = 512,
    localparam int BODY_ADDR_WIDTH = $clog2(BODIES)
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   pair_valid_i,
    input  wire                                   pair_last_i,
    input  wire [BODY_ADDR_WIDTH-1:0]             body_i_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  xi_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  yi_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  xj_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  yj_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  mj_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  vx_i,
    input  wire [nbody_calc_pkg::DATA_WIDTH-1:0]  vy_i,
    output logic                                  vel_we_o,
    output logic [BODY_ADDR_WIDTH-1:0]            vel_addr_o,
    output logic [nbody_calc_pkg::DATA_WIDTH-1:0] vx_new_o,
    output logic [nbody_calc_pkg::DATA_WIDTH-1:0] vy_new_o
);
    import nbody_calc_pkg::*;

    // Bit 0 lines up with the memory outputs, bit 3 with the shifted term
    logic [3:0]                 valid_q;
    logic [3:0]                 last_q;
    logic [BODY_ADDR_WIDTH-1:0] idx_q [0:3];
    logic signed [DATA_WIDTH-1:0] dx_q, dy_q, m_q;
    logic signed [DATA_WIDTH-1:0] px_q, py_q;
    logic signed [DATA_WIDTH-1:0] sx_q, sy_q;
    logic signed [DATA_WIDTH-1:0] vx1_q, vy1_q, vx2_q, vy2_q, vx3_q, vy3_q;
    logic signed [DATA_WIDTH-1:0] acc_x, acc_y;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            last_q   <= '0;
            acc_x    <= '0;
            acc_y    <= '0;
            vel_we_o <= 1'b0;
        end else begin
            valid_q  <= {valid_q[2:0], pair_valid_i};
            last_q   <= {last_q[2:0], pair_last_i};
            vel_we_o <= valid_q[3] && last_q[3];
            // Restart on the last pair so the next body follows with no gap
            if (valid_q[3]) begin
                if (last_q[3]) begin
                    acc_x <= '0;
                    acc_y <= '0;
                end else begin
                    acc_x <= acc_x + sx_q;
                    acc_y <= acc_y + sy_q;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        idx_q[0] <= body_i_i;
        idx_q[1] <= idx_q[0];
        idx_q[2] <= idx_q[1];
        idx_q[3] <= idx_q[2];
        // Differences, self pair gives zero here
        dx_q  <= $signed(xj_i) - $signed(xi_i);
        dy_q  <= $signed(yj_i) - $signed(yi_i);
        m_q   <= $signed(mj_i);
        vx1_q <= $signed(vx_i);
        vy1_q <= $signed(vy_i);
        // Mass products, low word only
        px_q  <= m_q * dx_q;
        py_q  <= m_q * dy_q;
        vx2_q <= vx1_q;
        vy2_q <= vy1_q;
        sx_q  <= px_q >>> FORCE_SHIFT;
        sy_q  <= py_q >>> FORCE_SHIFT;
        vx3_q <= vx2_q;
        vy3_q <= vy2_q;
        vx_new_o   <= vx3_q + acc_x + sx_q;
        vy_new_o   <= vy3_q + acc_y + sy_q;
        vel_addr_o <= idx_q[3];
    end

endmodule

`default_nettype wire

// File: test/nbody_tb_tasks.svh
`ifndef NBODY_TB_TASKS_SVH
`define NBODY_TB_TASKS_SVH

// One bus write, entered just after a rising edge
task automatic write_bus(input logic [OPCODE_WIDTH-1:0] op, input int idx,
                         input logic [EXT_DATA_WIDTH-1:0] data);
    chipselect = 1'b1;
    write_en   = 1'b1;
    addr       = {op, IDX_WIDTH'(idx)};
    writedata  = data;
    @(posedge clk);
    #10;
    chipselect = 1'b0;
    write_en   = 1'b0;
endtask

task automatic read_bus(input logic [OPCODE_WIDTH-1:0] op, input int idx,
                        output logic [EXT_DATA_WIDTH-1:0] data);
    chipselect = 1'b1;
    read_en    = 1'b1;
    addr       = {op, IDX_WIDTH'(idx)};
    @(posedge clk);
    #10;
    // Registered answer holds for this whole cycle
    data       = readdata;
    chipselect = 1'b0;
    read_en    = 1'b0;
endtask

// Low half is staged, high half commits the word
task automatic load_word(input logic [OPCODE_WIDTH-1:0] op_lo,
                         input logic [OPCODE_WIDTH-1:0] op_hi, input int idx,
                         input logic [DATA_WIDTH-1:0] value);
    write_bus(op_lo, idx, value[EXT_DATA_WIDTH-1:0]);
    write_bus(op_hi, idx, value[DATA_WIDTH-1:EXT_DATA_WIDTH]);
endtask

task automatic compare_word(input string what, input logic [EXT_DATA_WIDTH-1:0] got,
                            input logic [EXT_DATA_WIDTH-1:0] exp);
    checks++;
    assert (got === exp)
    else begin
        $display("MISMATCH at time %0t: %s read %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_body(input int idx);
    logic [EXT_DATA_WIDTH-1:0] word;
    read_bus(OP_RD_X_LO, idx, word);
    compare_word($sformatf("body %0d x low", idx), word, model_x[idx][31:0]);
    read_bus(OP_RD_X_HI, idx, word);
    compare_word($sformatf("body %0d x high", idx), word, model_x[idx][63:32]);
    read_bus(OP_RD_Y_LO, idx, word);
    compare_word($sformatf("body %0d y low", idx), word, model_y[idx][31:0]);
    read_bus(OP_RD_Y_HI, idx, word);
    compare_word($sformatf("body %0d y high", idx), word, model_y[idx][63:32]);
endtask

// All accelerations from the old positions, then velocities, then positions
task automatic step_model(input int n);
    logic signed [DATA_WIDTH-1:0] ax [0:BODIES-1];
    logic signed [DATA_WIDTH-1:0] ay [0:BODIES-1];
    logic signed [DATA_WIDTH-1:0] prod;
    int i;
    int j;
    for (i = 0; i < n; i++) begin
        ax[i] = '0;
        ay[i] = '0;
        // Self pair has zero difference
        for (j = 0; j < n; j++) begin
            prod  = model_m[j] * (model_x[j] - model_x[i]);
            ax[i] = ax[i] + (prod >>> FORCE_SHIFT);
            prod  = model_m[j] * (model_y[j] - model_y[i]);
            ay[i] = ay[i] + (prod >>> FORCE_SHIFT);
        end
    end
    for (i = 0; i < n; i++) begin
        model_vx[i] = model_vx[i] + ax[i];
        model_vy[i] = model_vy[i] + ay[i];
    end
    for (i = 0; i < n; i++) begin
        model_x[i] = model_x[i] + model_vx[i];
        model_y[i] = model_y[i] + model_vy[i];
    end
endtask

`endif

// File: test/nbody_tb.sv
`default_nettype none

module nbody_tb;
    import nbody_bus_pkg::*;
    import nbody_calc_pkg::*;

    localparam int BODIES = 16;
    localparam int IDX_WIDTH = ADDR_WIDTH - OPCODE_WIDTH;
    // Worst case per step is n*n + n + 10
    localparam int ABORT_WAIT = (16*16 + 16 + 10) * 3;
    localparam int STEP_CYCLES = (4*4 + 4 + 10) * 1 + (16*16 + 16 + 10) * (3 + 2) + ABORT_WAIT;
    localparam int BUS_CYCLES = 6 + 16*8 + (4*14 + 8) + (16*14 + 8) + (16*8 + 20);
    localparam int CYCLE_LIMIT = 2 * (STEP_CYCLES + BUS_CYCLES);

    logic                      clk;
    logic                      rst;
    logic                      chipselect;
    logic                      write_en;
    logic                      read_en;
    logic [ADDR_WIDTH-1:0]     addr;
    logic [EXT_DATA_WIDTH-1:0] writedata;
    logic [EXT_DATA_WIDTH-1:0] readdata;
    logic [EXT_DATA_WIDTH-1:0] word;

    logic signed [DATA_WIDTH-1:0] model_x [0:BODIES-1];
    logic signed [DATA_WIDTH-1:0] model_y [0:BODIES-1];
    logic signed [DATA_WIDTH-1:0] model_m [0:BODIES-1];
    logic signed [DATA_WIDTH-1:0] model_vx [0:BODIES-1];
    logic signed [DATA_WIDTH-1:0] model_vy [0:BODIES-1];

    integer seed;
    int     errors;
    int     checks;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;

    nbody_top #(.BODIES(BODIES)) dut0 (
        .clk(clk), .rst(rst), .chipselect_i(chipselect), .write_i(write_en),
        .read_i(read_en), .addr_i(addr), .writedata_i(writedata), .readdata_o(readdata)
    );

    `include "nbody_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not complete within %0d clock cycles", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    // Small random bodies mirrored into the model
    task automatic seed_bodies(input int n);
        int b;
        for (b = 0; b < n; b++) begin
            model_x[b]  = $random(seed) % 32768;
            model_y[b]  = $random(seed) % 32768;
            model_m[b]  = ($random(seed) & 255) + 1;
            model_vx[b] = $random(seed) % 256;
            model_vy[b] = $random(seed) % 256;
            load_word(OP_X_LO, OP_X_HI, b, model_x[b]);
            load_word(OP_Y_LO, OP_Y_HI, b, model_y[b]);
            load_word(OP_M_LO, OP_M_HI, b, model_m[b]);
            load_word(OP_VX_LO, OP_VX_HI, b, model_vx[b]);
            load_word(OP_VY_LO, OP_VY_HI, b, model_vy[b]);
        end
    endtask

    task automatic scan_bodies(input int n);
        int b;
        for (b = 0; b < n; b++) begin
            check_body(b);
        end
    endtask

    task automatic run_engine(input int n, input int gap);
        logic [EXT_DATA_WIDTH-1:0] done_word;
        write_bus(OP_N_BODIES, 0, n);
        write_bus(OP_GAP, 0, gap);
        write_bus(OP_GO, 0, 1);
        done_word = '0;
        while (done_word[0] !== 1'b1) begin
            read_bus(OP_DONE, 0, done_word);
        end
    endtask

    task automatic clear_done();
        write_bus(OP_GO, 0, 0);
        write_bus(OP_READ, 0, 1);
        write_bus(OP_READ, 0, 0);
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_errors);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    initial begin
        seed         = 56108;
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        chipselect   = 1'b0;
        write_en     = 1'b0;
        read_en      = 1'b0;
        addr         = '0;
        writedata    = '0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        compare_word("readdata after reset", readdata, '0);
        read_bus(OP_DONE, 0, word);
        compare_word("DONE after reset", word, '0);
        read_bus(7'h10, 0, word);
        compare_word("unmapped opcode", word, '1);
        @(posedge clk);
        #10;
        compare_word("readdata with no read", readdata, '0);
        close_test("reset state");

        // Full 64-bit words exercise both halves
        for (int b = 0; b < BODIES; b++) begin
            model_x[b] = {$random(seed), $random(seed)};
            model_y[b] = {$random(seed), $random(seed)};
            load_word(OP_X_LO, OP_X_HI, b, model_x[b]);
            load_word(OP_Y_LO, OP_Y_HI, b, model_y[b]);
        end
        scan_bodies(BODIES);
        close_test("position load and readback");

        seed_bodies(4);
        run_engine(4, 0);
        step_model(4);
        scan_bodies(4);
        close_test("single step with four bodies");

        clear_done();
        seed_bodies(BODIES);
        run_engine(BODIES, 3);
        repeat (3) step_model(BODIES);
        scan_bodies(BODIES);
        close_test("three steps with sixteen bodies");

        write_bus(OP_READ, 0, 1);
        read_bus(OP_DONE, 0, word);
        compare_word("DONE after READ", word, '0);
        // GO is still set so releasing READ restarts the engine
        write_bus(OP_READ, 0, 0);
        write_bus(OP_GO, 0, 0);
        // An engine that kept running would have finished all three steps by now
        repeat (ABORT_WAIT) @(posedge clk);
        #10;
        read_bus(OP_DONE, 0, word);
        compare_word("DONE after abort", word, '0);
        scan_bodies(BODIES);
        run_engine(BODIES, 2);
        repeat (2) step_model(BODIES);
        scan_bodies(BODIES);
        close_test("abort and rerun");

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
